// File: build.f
hdl/debugPkg.sv
hdl/asyncFifo.sv
hdl/debugSerial.sv
hdl/debugBridge.sv
hdl/respArbiter.sv
hdl/ledControl.sv
hdl/scratchLog.sv
hdl/debugTop.sv
verification/debugTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module debugTb -o simDebug

simOut=$(./obj_dir/simDebug 2>&1) || true
echo "$simOut"

if echo "$simOut" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: verification/debugTb.sv
`timescale 1ns/100ps

module debugTb;

    localparam int ClkHalfNs    = 5;
    localparam int DebugHalfNs  = 13;
    localparam int FrameNs      = 16 * DebugHalfNs;
    localparam int CmdBudget    = 48;
    localparam int FramesPerCmd = 20;
    // About 200 us for the whole run
    localparam int WatchdogNs   = CmdBudget * FramesPerCmd * FrameNs;
    localparam int BurstReads   = 20;

    logic clk;
    logic arstN;
    logic debugClk;
    logic debugCs;
    logic debugDi;
    logic debugDo;
    logic led;

    // Scoreboard, one queue of expected payloads per unit
    debugPkg::byteT ledQ [$];
    logic [31:0]    logQ [$];
    logic [3:0]     logModel [$];

    // Receive parser state
    logic           inMsg;
    int             rxLeft;
    debugPkg::byteT rxLen;
    logic [31:0]    rxPayload;

    logic [15:0] lfsrState;
    logic        expectedLed;
    string       testName;
    int          fullCycles = 0;

    debugTop #(
        .InFifoDepth  (8),
        .OutFifoDepth (16)
    ) u_debugTop (
        .clk      (clk),
        .arstN    (arstN),
        .debugClk (debugClk),
        .debugCs  (debugCs),
        .debugDi  (debugDi),
        .debugDo  (debugDo),
        .led      (led)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkHalfNs) clk = ~clk;
    end

    initial begin
        debugClk = 1'b0;
        forever #(DebugHalfNs) debugClk = ~debugClk;
    end

    // Counts system cycles with the outbound FIFO full
    always @(negedge clk) begin
        if (!u_debugTop.outNotFull) begin
            fullCycles <= fullCycles + 1;
        end
    end

    // ====================
    // Checking
    // ====================
    task automatic stopRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic failWith(input string reason);
        $display("ERROR in test %s: %s", testName, reason);
        stopRun();
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH test %s, %s: expected %h actual %h",
                     testName, what, expected, actual);
            stopRun();
        end
    endtask

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic logic [3:0] randNibble();
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 4; i++) begin
            n = {n[2:0], lfsrStep()};
        end
        return n;
    endfunction

    // Length tells the unit apart, 1 for LED and 4 for the log
    task automatic finishMessage();
        debugPkg::byteT ledExp;
        logic [31:0]    logExp;
        if (rxLen == 8'd1) begin
            assert (ledQ.size() != 0) else failWith("LED echo with none outstanding");
            ledExp = ledQ.pop_front();
            checkValue("LED echo", 32'(ledExp), rxPayload);
        end else begin
            assert (logQ.size() != 0) else failWith("log read-out with none outstanding");
            logExp = logQ.pop_front();
            checkValue("log read-out", logExp, rxPayload);
        end
    endtask

    task automatic consumeRxByte(input debugPkg::byteT b);
        if (!inMsg) begin
            // Zero bytes between messages are idle fill
            if (b != 8'h00) begin
                assert (b == 8'd1 || b == 8'd4) else
                    failWith($sformatf("response length %0d is neither 1 nor 4", b));
                inMsg     = 1'b1;
                rxLen     = b;
                rxLeft    = int'(b);
                rxPayload = '0;
            end
        end else begin
            rxPayload = {rxPayload[23:0], b};
            rxLeft    = rxLeft - 1;
            if (rxLeft == 0) begin
                inMsg = 1'b0;
                finishMessage();
            end
        end
    endtask

    // ====================
    // Serial host
    // ====================

    // Output sampled after the edge, input set up for the next edge
    task automatic shiftBit(input logic di, output logic dout);
        @(posedge debugClk);
        #1;
        dout    = debugDo;
        debugDi = di;
    endtask

    task automatic raiseCs();
        @(posedge debugClk);
        #1;
        debugCs = 1'b1;
    endtask

    // Called right after a full byte, so no output byte is cut
    task automatic dropCs();
        debugCs = 1'b0;
    endtask

    task automatic exchangeByte(input debugPkg::byteT tx);
        debugPkg::byteT rx;
        logic           b;
        for (int i = 7; i >= 0; i--) begin
            shiftBit(tx[i], b);
            rx[i] = b;
        end
        consumeRxByte(rx);
    endtask

    task automatic sendByte(input debugPkg::byteT cmd);
        exchangeByte(cmd);
    endtask

    task automatic idleBytes(input int count);
        repeat (count) begin
            exchangeByte(8'h00);
        end
    endtask

    // Shifts idle bytes until every expected response is in
    task automatic receiveAll();
        while (ledQ.size() != 0 || logQ.size() != 0 || inMsg) begin
            exchangeByte(8'h00);
        end
    endtask

    task automatic ledCommand(input logic on);
        debugPkg::byteT c;
        c = {7'b1000000, on};
        ledQ.push_back(c);
        expectedLed = on;
        sendByte(c);
    endtask

    task automatic logPush(input logic [3:0] n);
        logModel.push_back(n);
        if (logModel.size() > 4) begin
            logModel.delete(0);
        end
        sendByte({4'hA, n});
    endtask

    // Oldest entry goes first on the wire
    task automatic logRead();
        logic [31:0] expected;
        expected = {4'h0, logModel[0], 4'h0, logModel[1],
                    4'h0, logModel[2], 4'h0, logModel[3]};
        logQ.push_back(expected);
        sendByte(8'hB0);
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic doBit;
        int   fullBefore;
        arstN       = 1'b0;
        debugCs     = 1'b0;
        debugDi     = 1'b0;
        lfsrState   = 16'd23;
        inMsg       = 1'b0;
        rxLeft      = 0;
        rxLen       = '0;
        rxPayload   = '0;
        expectedLed = 1'b0;
        testName    = "reset";
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;
        repeat (4) @(posedge clk);

        testName = "reset state";
        checkValue("led after reset", 32'h0, 32'(led));
        raiseCs();
        repeat (32) begin
            shiftBit(1'b0, doBit);
            checkValue("idle debugDo", 32'h0, 32'(doBit));
        end

        testName = "led on off";
        ledCommand(1'b1);
        receiveAll();
        checkValue("led level", 32'h1, 32'(led));
        ledCommand(1'b0);
        receiveAll();
        checkValue("led level", 32'h0, 32'(led));

        testName = "log push and read";
        repeat (8) begin
            logPush(randNibble());
        end
        logRead();
        receiveAll();

        testName = "unknown unit";
        sendByte(8'h90);
        ledCommand(1'b1);
        receiveAll();
        // A reply to 0x90 would land here as an unexpected message
        idleBytes(4);

        testName = "interleaved units";
        for (int n = 0; n < 10; n++) begin
            if (lfsrStep()) begin
                ledCommand(lfsrStep());
            end else begin
                logRead();
            end
        end
        receiveAll();
        checkValue("led level", 32'(expectedLed), 32'(led));

        testName = "back-pressure burst";
        fullBefore = fullCycles;
        // Host drains slower than the bridge produces
        repeat (BurstReads) begin
            logRead();
            idleBytes(2);
        end
        dropCs();
        repeat (300) @(posedge clk);
        assert (fullCycles > fullBefore) else failWith("outbound FIFO never became full");
        raiseCs();
        receiveAll();
        idleBytes(4);

        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(WatchdogNs);
        failWith($sformatf("watchdog expired after %0d ns", WatchdogNs));
    end

endmodule

// File: hdl/debugTop.sv
`timescale 1ns/100ps

module debugTop #(
    parameter int InFifoDepth  = 8,
    parameter int OutFifoDepth = 16
) (
    input  logic clk,
    input  logic arstN,
    input  logic debugClk,
    input  logic debugCs,
    input  logic debugDi,
    output logic debugDo,
    output logic led
);
    logic                                   inWrEn;
    logic                                   inNotFull;
    logic                                   inRdEn;
    logic                                   inNotEmpty;
    debugPkg::byteT                         inWrData;
    debugPkg::byteT                         inRdData;
    logic                                   outWrEn;
    logic                                   outNotFull;
    logic                                   outRdEn;
    logic                                   outNotEmpty;
    debugPkg::byteT                         outWrData;
    debugPkg::byteT                         outRdData;
    debugPkg::byteT                         cmd;
    logic [debugPkg::NumPeers-1:0]          cmdValid;
    logic [debugPkg::NumPeers-1:0]          peerBusy;
    logic [debugPkg::NumPeers-1:0]          peerTaken;
    debugPkg::respT [debugPkg::NumPeers-1:0] peerResp;
    debugPkg::respT                         resp;
    logic                                   byteTaken;

    // ====================
    // Clock crossing
    // ====================
    asyncFifo #(.FifoDepth(InFifoDepth)) u_inFifo (
        .wrClk    (debugClk),
        .wrArstN  (arstN),
        .wrEn     (inWrEn),
        .wrData   (inWrData),
        .notFull  (inNotFull),
        .rdClk    (clk),
        .rdArstN  (arstN),
        .rdEn     (inRdEn),
        .rdData   (inRdData),
        .notEmpty (inNotEmpty)
    );

    asyncFifo #(.FifoDepth(OutFifoDepth)) u_outFifo (
        .wrClk    (clk),
        .wrArstN  (arstN),
        .wrEn     (outWrEn),
        .wrData   (outWrData),
        .notFull  (outNotFull),
        .rdClk    (debugClk),
        .rdArstN  (arstN),
        .rdEn     (outRdEn),
        .rdData   (outRdData),
        .notEmpty (outNotEmpty)
    );

    debugSerial u_debugSerial (
        .debugClk    (debugClk),
        .arstN       (arstN),
        .debugCs     (debugCs),
        .debugDi     (debugDi),
        .debugDo     (debugDo),
        .inWrEn      (inWrEn),
        .inWrData    (inWrData),
        .inNotFull   (inNotFull),
        .outRdEn     (outRdEn),
        .outRdData   (outRdData),
        .outNotEmpty (outNotEmpty)
    );

    // ====================
    // System side
    // ====================
    debugBridge u_debugBridge (
        .clk        (clk),
        .arstN      (arstN),
        .inRdEn     (inRdEn),
        .inRdData   (inRdData),
        .inNotEmpty (inNotEmpty),
        .cmd        (cmd),
        .cmdValid   (cmdValid),
        .peerBusy   (peerBusy),
        .resp       (resp),
        .byteTaken  (byteTaken),
        .outWrEn    (outWrEn),
        .outWrData  (outWrData),
        .outNotFull (outNotFull)
    );

    respArbiter u_respArbiter (
        .clk       (clk),
        .arstN     (arstN),
        .peerResp  (peerResp),
        .peerTaken (peerTaken),
        .resp      (resp),
        .byteTaken (byteTaken)
    );

    ledControl u_ledControl (
        .clk       (clk),
        .arstN     (arstN),
        .cmdValid  (cmdValid[debugPkg::LedPeer]),
        .cmd       (cmd),
        .busy      (peerBusy[debugPkg::LedPeer]),
        .resp      (peerResp[debugPkg::LedPeer]),
        .byteTaken (peerTaken[debugPkg::LedPeer]),
        .led       (led)
    );

    scratchLog u_scratchLog (
        .clk       (clk),
        .arstN     (arstN),
        .cmdValid  (cmdValid[debugPkg::LogPeer]),
        .cmd       (cmd),
        .busy      (peerBusy[debugPkg::LogPeer]),
        .resp      (peerResp[debugPkg::LogPeer]),
        .byteTaken (peerTaken[debugPkg::LogPeer])
    );

endmodule

// File: hdl/scratchLog.sv
`timescale 1ns/100ps

module scratchLog (
    input  logic           clk,
    input  logic           arstN,
    input  logic           cmdValid,
    input  debugPkg::byteT cmd,
    output logic           busy,
    output debugPkg::respT resp,
    input  logic           byteTaken
);
    localparam int LogDepth = 4;

    typedef logic [3:0] nibbleT;

    // Entry 0 is the oldest
    nibbleT           logEntry [LogDepth];
    nibbleT           snapshot [LogDepth];
    debugPkg::msgLenT respLen;
    debugPkg::unitT   unit;
    logic             push;
    logic             readOut;

    assign unit    = cmd[6:4];
    assign push    = cmdValid && unit == debugPkg::UnitLogPush;
    assign readOut = cmdValid && unit == debugPkg::UnitLogRead;

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < LogDepth - 1; i++) begin
                logEntry[i] <= logEntry[i+1];
            end
            logEntry[LogDepth-1] <= cmd[3:0];
        end
        if (readOut) begin
            snapshot <= logEntry;
        end else if (byteTaken) begin
            // Move the next entry to the head
            for (int i = 0; i < LogDepth - 1; i++) begin
                snapshot[i] <= snapshot[i+1];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            respLen <= '0;
        end else if (readOut) begin
            respLen <= debugPkg::msgLenT'(LogDepth);
        end else if (byteTaken && respLen != '0) begin
            respLen <= respLen - 1'b1;
        end
    end

    assign busy = respLen != '0;
    assign resp = '{len: respLen, data: {4'h0, snapshot[0]}};

endmodule

// File: hdl/ledControl.sv
`timescale 1ns/100ps

module ledControl (
    input  logic           clk,
    input  logic           arstN,
    input  logic           cmdValid,
    input  debugPkg::byteT cmd,
    output logic           busy,
    output debugPkg::respT resp,
    input  logic           byteTaken,
    output logic           led
);
    debugPkg::msgLenT respLen;
    debugPkg::byteT   echo;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            led     <= 1'b0;
            respLen <= '0;
        end else if (cmdValid) begin
            // 0x80 clears, 0x81 sets
            led     <= cmd[0];
            respLen <= debugPkg::msgLenT'(1);
        end else if (byteTaken && respLen != '0) begin
            respLen <= respLen - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid) begin
            echo <= cmd;
        end
    end

    assign busy = respLen != '0;
    assign resp = '{len: respLen, data: echo};

endmodule

// File: hdl/respArbiter.sv
`timescale 1ns/100ps

module respArbiter (
    input  logic                                    clk,
    input  logic                                    arstN,
    input  debugPkg::respT [debugPkg::NumPeers-1:0] peerResp,
    output logic [debugPkg::NumPeers-1:0]           peerTaken,
    output debugPkg::respT                          resp,
    input  logic                                    byteTaken
);
    localparam int IdxW = (debugPkg::NumPeers > 1) ? $clog2(debugPkg::NumPeers) : 1;

    typedef logic [IdxW-1:0] peerIdxT;

    logic    locked;
    logic    anyReq;
    peerIdxT owner;
    peerIdxT rrPtr;
    peerIdxT winner;

    function automatic peerIdxT nextPeer(peerIdxT idx);
        return (int'(idx) == debugPkg::NumPeers - 1) ? '0 : idx + 1'b1;
    endfunction

    // Scan from the lowest priority so the peer at rrPtr wins last
    always_comb begin
        int idx;
        winner = rrPtr;
        anyReq = 1'b0;
        for (int i = debugPkg::NumPeers - 1; i >= 0; i--) begin
            idx = (int'(rrPtr) + i) % debugPkg::NumPeers;
            if (peerResp[idx].len != '0) begin
                winner = peerIdxT'(idx);
                anyReq = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            locked <= 1'b0;
            owner  <= '0;
            rrPtr  <= '0;
        end else if (!locked) begin
            if (anyReq) begin
                locked <= 1'b1;
                owner  <= winner;
            end
        end else if (byteTaken && resp.len == debugPkg::msgLenT'(1)) begin
            // Last payload byte, release and rotate
            locked <= 1'b0;
            rrPtr  <= nextPeer(owner);
        end
    end

    assign resp = locked ? peerResp[owner] : '0;

    always_comb begin
        peerTaken = '0;
        if (locked) begin
            peerTaken[owner] = byteTaken;
        end
    end

endmodule

// File: hdl/debugBridge.sv
`timescale 1ns/100ps

module debugBridge (
    input  logic                            clk,
    input  logic                            arstN,
    output logic                            inRdEn,
    input  debugPkg::byteT                  inRdData,
    input  logic                            inNotEmpty,
    output debugPkg::byteT                  cmd,
    output logic [debugPkg::NumPeers-1:0]   cmdValid,
    input  logic [debugPkg::NumPeers-1:0]   peerBusy,
    input  debugPkg::respT                  resp,
    output logic                            byteTaken,
    output logic                            outWrEn,
    output debugPkg::byteT                  outWrData,
    input  logic                            outNotFull
);
    typedef enum logic [1:0] {
        StIdle,
        StSendLen,
        StSendData
    } stateT;

    stateT                          state;
    stateT                          stateNext;
    debugPkg::unitT                 unit;
    logic [debugPkg::NumPeers-1:0]  target;

    // ====================
    // Command dispatch
    // ====================
    assign unit = inRdData[6:4];

    // One-hot peer select, all zero for an unknown unit
    always_comb begin
        target = '0;
        case (unit)
            debugPkg::UnitLed: begin
                target[debugPkg::LedPeer] = 1'b1;
            end
            debugPkg::UnitLogPush, debugPkg::UnitLogRead: begin
                target[debugPkg::LogPeer] = 1'b1;
            end
            default: begin
                target = '0;
            end
        endcase
    end

    // Unknown units pop straight through and vanish
    assign inRdEn   = inNotEmpty && !(|(target & peerBusy));
    assign cmdValid = inRdEn ? target : '0;
    assign cmd      = inRdData;

    // ====================
    // Message writer
    // ====================
    always_comb begin
        stateNext = state;
        outWrEn   = 1'b0;
        outWrData = resp.data;
        byteTaken = 1'b0;
        case (state)
            StIdle: begin
                if (resp.len != '0) begin
                    stateNext = StSendLen;
                end
            end
            StSendLen: begin
                outWrEn   = outNotFull;
                outWrData = debugPkg::byteT'(resp.len);
                if (outNotFull) begin
                    stateNext = StSendData;
                end
            end
            StSendData: begin
                outWrEn   = outNotFull;
                byteTaken = outNotFull;
                if (outNotFull && resp.len == debugPkg::msgLenT'(1)) begin
                    stateNext = StIdle;
                end
            end
            default: begin
                stateNext = StIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= StIdle;
        end else begin
            state <= stateNext;
        end
    end

endmodule

// File: hdl/debugSerial.sv
`timescale 1ns/100ps

module debugSerial (
    input  logic           debugClk,
    input  logic           arstN,
    input  logic           debugCs,
    input  logic           debugDi,
    output logic           debugDo,
    output logic           inWrEn,
    output debugPkg::byteT inWrData,
    input  logic           inNotFull,
    output logic           outRdEn,
    input  debugPkg::byteT outRdData,
    input  logic           outNotEmpty
);
    // Bit position within the current output byte
    typedef logic [2:0] bitIdxT;

    debugPkg::byteT inShift;
    debugPkg::byteT outShift;
    bitIdxT         bitCnt;
    logic           byteDone;
    logic           byteStart;

    // ====================
    // Host to FIFO
    // ====================

    // A byte is framed once its leading one reaches the MSB
    assign byteDone = inShift[7];

    // Dropped when the inbound FIFO has no room
    assign inWrEn   = byteDone && inNotFull;
    assign inWrData = inShift;

    always_ff @(posedge debugClk or negedge arstN) begin
        if (!arstN) begin
            inShift <= '0;
        end else if (!debugCs) begin
            inShift <= '0;
        end else if (byteDone) begin
            // Next byte starts with the bit sampled on this edge
            inShift <= {7'b0, debugDi};
        end else begin
            inShift <= {inShift[6:0], debugDi};
        end
    end

    // ====================
    // FIFO to host
    // ====================
    assign byteStart = debugCs && (bitCnt == '0);
    assign outRdEn   = byteStart && outNotEmpty;
    assign debugDo   = outShift[7];

    always_ff @(posedge debugClk or negedge arstN) begin
        if (!arstN) begin
            bitCnt   <= '0;
            outShift <= '0;
        end else if (!debugCs) begin
            // Realign to byte 0 on the next select
            bitCnt   <= '0;
            outShift <= '0;
        end else begin
            bitCnt <= bitCnt + 1'b1;
            if (byteStart) begin
                outShift <= outNotEmpty ? outRdData : '0;
            end else begin
                outShift <= {outShift[6:0], 1'b0};
            end
        end
    end

endmodule

// File: hdl/asyncFifo.sv
`timescale 1ns/100ps

module asyncFifo #(
    parameter int FifoDepth = 8
) (
    input  logic           wrClk,
    input  logic           wrArstN,
    input  logic           wrEn,
    input  debugPkg::byteT wrData,
    output logic           notFull,
    input  logic           rdClk,
    input  logic           rdArstN,
    input  logic           rdEn,
    output debugPkg::byteT rdData,
    output logic           notEmpty
);
    localparam int AddrW = $clog2(FifoDepth);

    // Pointers carry one extra wrap bit
    typedef logic [AddrW:0] ptrT;

    // Top two Gray bits differ when the writer is a full lap ahead
    localparam ptrT FullMask = ptrT'(3) << (AddrW - 1);

    debugPkg::byteT mem [FifoDepth];

    ptrT  wrBin;
    ptrT  wrGray;
    ptrT  wrBinNext;
    ptrT  rdBin;
    ptrT  rdGray;
    ptrT  rdBinNext;
    ptrT  rdGraySync1;
    ptrT  rdGraySync2;
    ptrT  wrGraySync1;
    ptrT  wrGraySync2;
    logic wrFire;
    logic rdFire;

    function automatic ptrT binToGray(ptrT bin);
        return bin ^ (bin >> 1);
    endfunction

    // ====================
    // Write domain
    // ====================
    assign wrBinNext = wrBin + 1'b1;
    assign notFull   = wrGray != (rdGraySync2 ^ FullMask);
    assign wrFire    = wrEn && notFull;

    always_ff @(posedge wrClk or negedge wrArstN) begin
        if (!wrArstN) begin
            wrBin       <= '0;
            wrGray      <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
        end else begin
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
            if (wrFire) begin
                wrBin  <= wrBinNext;
                wrGray <= binToGray(wrBinNext);
            end
        end
    end

    always_ff @(posedge wrClk) begin
        if (wrFire) begin
            mem[wrBin[AddrW-1:0]] <= wrData;
        end
    end

    // ====================
    // Read domain
    // ====================
    assign rdBinNext = rdBin + 1'b1;
    assign notEmpty  = rdGray != wrGraySync2;
    assign rdFire    = rdEn && notEmpty;

    // Fall-through, the head entry is always on rdData
    assign rdData = mem[rdBin[AddrW-1:0]];

    always_ff @(posedge rdClk or negedge rdArstN) begin
        if (!rdArstN) begin
            rdBin       <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
        end else begin
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
            if (rdFire) begin
                rdBin  <= rdBinNext;
                rdGray <= binToGray(rdBinNext);
            end
        end
    end

endmodule

// File: hdl/debugPkg.sv
package debugPkg;

    // ====================
    // Link types
    // ====================

    // One byte on the serial link or in a FIFO
    typedef logic [7:0] byteT;

    // Payload bytes still to send, zero when idle
    typedef logic [7:0] msgLenT;

    // Unit field of a command, bits 6..4
    typedef logic [2:0] unitT;

    localparam unitT UnitLed     = 3'd0;
    localparam unitT UnitLogPush = 3'd2;
    localparam unitT UnitLogRead = 3'd3;

    // ====================
    // Peer units
    // ====================

    localparam int NumPeers = 2;

    // Slot of each peer in the command and response vectors
    localparam int LedPeer = 0;
    localparam int LogPeer = 1;

    // Response offered by a peer, data is the byte at the head
    typedef struct packed {
        msgLenT len;
        byteT   data;
    } respT;

endpackage
